/* logic/cache_mem_pkg.sv */
package cache_mem_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // beats per burst is len + 1
    localparam int LEN_W  = 8;

    // added to each word's byte address at start-up
    localparam logic [31:0] MEM_INIT_BASE = 32'h8000_0000;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_DATA,
        ARB_INST
    } arb_state_t;

    // requester tag carried on the shared bus
    typedef enum logic {
        ID_DATA = 1'b0,
        ID_INST = 1'b1
    } req_id_t;

endpackage

/* logic/req_arbiter.sv */
`timescale 1ns/100ps

module req_arbiter (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic [cache_mem_pkg::ADDR_W-1:0] i_ic_araddr,
    input  logic [cache_mem_pkg::LEN_W-1:0]  i_ic_arlen,
    input  logic                             i_ic_arvalid,
    input  logic [cache_mem_pkg::ADDR_W-1:0] i_dc_araddr,
    input  logic [cache_mem_pkg::LEN_W-1:0]  i_dc_arlen,
    input  logic                             i_dc_arvalid,
    input  logic                             i_bus_arready,
    output logic                             o_ic_arready,
    output logic                             o_dc_arready,
    output logic [cache_mem_pkg::ADDR_W-1:0] o_bus_araddr,
    output logic [cache_mem_pkg::LEN_W-1:0]  o_bus_arlen,
    output cache_mem_pkg::req_id_t           o_bus_arid,
    output logic                             o_bus_arvalid
);

    import cache_mem_pkg::*;

    arb_state_t state;
    logic       gnt_data;
    logic       gnt_inst;

    assign gnt_data = (state == ARB_DATA);
    assign gnt_inst = (state == ARB_INST);

    // grant is registered, so it cannot move while a request is waiting
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // data cache wins a tie
                    if (i_dc_arvalid) begin
                        state <= ARB_DATA;
                    end else if (i_ic_arvalid) begin
                        state <= ARB_INST;
                    end
                end
                default: begin
                    if (o_bus_arvalid && i_bus_arready) begin
                        state <= ARB_IDLE;
                    end
                end
            endcase
        end
    end

    assign o_bus_arvalid = (gnt_data && i_dc_arvalid) || (gnt_inst && i_ic_arvalid);
    assign o_bus_araddr  = gnt_inst ? i_ic_araddr : i_dc_araddr;
    assign o_bus_arlen   = gnt_inst ? i_ic_arlen : i_dc_arlen;
    assign o_bus_arid    = gnt_inst ? ID_INST : ID_DATA;

    assign o_dc_arready = i_bus_arready && gnt_data;
    assign o_ic_arready = i_bus_arready && gnt_inst;

endmodule

/* logic/resp_router.sv */
`timescale 1ns/100ps

module resp_router (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic [cache_mem_pkg::DATA_W-1:0] i_bus_rdata,
    input  cache_mem_pkg::req_id_t           i_bus_rid,
    input  logic                             i_bus_rlast,
    input  logic                             i_bus_rvalid,
    input  logic                             i_ic_rready,
    input  logic                             i_dc_rready,
    output logic                             o_bus_rready,
    output logic [cache_mem_pkg::DATA_W-1:0] o_ic_rdata,
    output logic                             o_ic_rlast,
    output logic                             o_ic_rvalid,
    output logic [cache_mem_pkg::DATA_W-1:0] o_dc_rdata,
    output logic                             o_dc_rlast,
    output logic                             o_dc_rvalid
);

    import cache_mem_pkg::*;

    // one-entry buffer per requester, indexed by bus id
    logic [1:0]        buf_vld;
    logic [1:0]        buf_last;
    logic [DATA_W-1:0] buf_data [2];
    logic [1:0]        req_rready;
    logic [1:0]        buf_open;
    logic [1:0]        take;

    assign req_rready[ID_DATA] = i_dc_rready;
    assign req_rready[ID_INST] = i_ic_rready;

    // empty, or emptied by the requester this cycle
    assign buf_open     = ~buf_vld | req_rready;
    assign o_bus_rready = buf_open[i_bus_rid];
    assign take         = (i_bus_rvalid && o_bus_rready) ? (2'b01 << i_bus_rid) : 2'b00;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            buf_vld <= 2'b00;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (take[i]) begin
                    buf_vld[i] <= 1'b1;
                end else if (req_rready[i]) begin
                    buf_vld[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (take[i]) begin
                buf_data[i] <= i_bus_rdata;
                buf_last[i] <= i_bus_rlast;
            end
        end
    end

    assign o_ic_rdata  = buf_data[ID_INST];
    assign o_ic_rlast  = buf_last[ID_INST];
    assign o_ic_rvalid = buf_vld[ID_INST];
    assign o_dc_rdata  = buf_data[ID_DATA];
    assign o_dc_rlast  = buf_last[ID_DATA];
    assign o_dc_rvalid = buf_vld[ID_DATA];

endmodule

/* logic/axi_read_engine.sv */
`timescale 1ns/100ps

module axi_read_engine #(
    parameter int MEM_WORDS = 256
) (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic [cache_mem_pkg::ADDR_W-1:0] i_araddr,
    input  logic [cache_mem_pkg::LEN_W-1:0]  i_arlen,
    input  cache_mem_pkg::req_id_t           i_arid,
    input  logic                             i_arvalid,
    input  logic                             i_rready,
    input  logic [cache_mem_pkg::DATA_W-1:0] i_mem_rdata,
    output logic                             o_arready,
    output logic [cache_mem_pkg::DATA_W-1:0] o_rdata,
    output cache_mem_pkg::req_id_t           o_rid,
    output logic                             o_rlast,
    output logic                             o_rvalid,
    output logic [$clog2(MEM_WORDS)-1:0]     o_mem_raddr
);

    import cache_mem_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_BEAT
    } rd_state_t;

    rd_state_t        state;
    logic [AW-1:0]    rd_addr;
    logic [AW-1:0]    next_addr;
    logic [LEN_W-1:0] beat_cnt;
    logic [LEN_W-1:0] len_q;
    req_id_t          id_q;
    logic             ar_fire;
    logic             r_fire;

    assign ar_fire   = i_arvalid && o_arready;
    assign r_fire    = o_rvalid && i_rready;
    assign next_addr = (rd_addr == AW'(MEM_WORDS - 1)) ? '0 : rd_addr + 1'b1;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        state <= RD_FETCH;
                    end
                end
                // ram read in flight
                RD_FETCH: state <= RD_BEAT;
                default: begin
                    if (r_fire && o_rlast) begin
                        state <= RD_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_addr  <= AW'((i_araddr >> 2) % MEM_WORDS);
            len_q    <= i_arlen;
            id_q     <= i_arid;
            beat_cnt <= '0;
        end else if (r_fire && !o_rlast) begin
            rd_addr  <= next_addr;
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // next word goes to the ram in the cycle its predecessor leaves
    assign o_mem_raddr = (r_fire && !o_rlast) ? next_addr : rd_addr;

    assign o_arready = (state == RD_IDLE);
    assign o_rvalid  = (state == RD_BEAT);
    assign o_rdata   = i_mem_rdata;
    assign o_rid     = id_q;
    assign o_rlast   = (beat_cnt == len_q);

endmodule

/* logic/axi_write_engine.sv */
`timescale 1ns/100ps

module axi_write_engine #(
    parameter int MEM_WORDS = 256
) (
    input  logic                               clk,
    input  logic                               i_rst_n,
    input  logic [cache_mem_pkg::ADDR_W-1:0]   i_awaddr,
    input  logic [cache_mem_pkg::LEN_W-1:0]    i_awlen,
    input  logic                               i_awvalid,
    input  logic [cache_mem_pkg::DATA_W-1:0]   i_wdata,
    input  logic [cache_mem_pkg::DATA_W/8-1:0] i_wstrb,
    input  logic                               i_wlast,
    input  logic                               i_wvalid,
    input  logic                               i_bready,
    output logic                               o_awready,
    output logic                               o_wready,
    output logic                               o_bvalid,
    output logic                               o_mem_we,
    output logic [$clog2(MEM_WORDS)-1:0]       o_mem_waddr,
    output logic [cache_mem_pkg::DATA_W-1:0]   o_mem_wdata,
    output logic [cache_mem_pkg::DATA_W/8-1:0] o_mem_wstrb
);

    import cache_mem_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    wr_state_t        state;
    logic [AW-1:0]    wr_addr;
    logic [AW-1:0]    start_addr;
    logic [AW-1:0]    next_addr;
    logic [LEN_W-1:0] len_q;
    logic [LEN_W-1:0] beat_cnt;
    logic             w_fire;

    assign o_awready = (state == WR_ADDR) && i_awvalid;
    assign o_wready  = (state == WR_DATA);
    assign o_bvalid  = (state == WR_RESP);
    assign w_fire    = i_wvalid && o_wready;
    assign next_addr = (wr_addr == AW'(MEM_WORDS - 1)) ? '0 : wr_addr + 1'b1;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= WR_ADDR;
        end else begin
            case (state)
                WR_ADDR: begin
                    if (o_awready) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_fire && i_wlast) begin
                        state <= WR_RESP;
                    end
                end
                default: begin
                    // held here until the response is taken
                    if (i_bready) begin
                        state <= WR_ADDR;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_awready) begin
            start_addr <= AW'((i_awaddr >> 2) % MEM_WORDS);
            wr_addr    <= AW'((i_awaddr >> 2) % MEM_WORDS);
            len_q      <= i_awlen;
            beat_cnt   <= '0;
        end else if (w_fire) begin
            // overrun past len wraps back to the burst start
            if (beat_cnt == len_q) begin
                wr_addr  <= start_addr;
                beat_cnt <= '0;
            end else begin
                wr_addr  <= next_addr;
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    assign o_mem_we    = w_fire;
    assign o_mem_waddr = wr_addr;
    assign o_mem_wdata = i_wdata;
    assign o_mem_wstrb = i_wstrb;

endmodule

/* logic/mem_array.sv */
`timescale 1ns/100ps

module mem_array #(
    parameter int MEM_WORDS = 256
) (
    input  logic                               clk,
    input  logic [$clog2(MEM_WORDS)-1:0]       i_raddr,
    input  logic                               i_we,
    input  logic [$clog2(MEM_WORDS)-1:0]       i_waddr,
    input  logic [cache_mem_pkg::DATA_W-1:0]   i_wdata,
    input  logic [cache_mem_pkg::DATA_W/8-1:0] i_wstrb,
    output logic [cache_mem_pkg::DATA_W-1:0]   o_rdata
);

    import cache_mem_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];

    // byte address plus base, so reads are predictable
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = DATA_W'(i * 4) + MEM_INIT_BASE;
        end
    end

    always_ff @(posedge clk) begin
        if (i_we) begin
            for (int b = 0; b < DATA_W / 8; b++) begin
                if (i_wstrb[b]) begin
                    mem[i_waddr][b*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
        end
    end

    // one-cycle read, old data on a same-address write
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

/* logic/cache_mem_top.sv */
`timescale 1ns/100ps

module cache_mem_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                               clk,
    input  logic                               i_rst_n,
    // instruction cache
    input  logic [cache_mem_pkg::ADDR_W-1:0]   i_ic_araddr,
    input  logic [cache_mem_pkg::LEN_W-1:0]    i_ic_arlen,
    input  logic                               i_ic_arvalid,
    output logic                               o_ic_arready,
    output logic [cache_mem_pkg::DATA_W-1:0]   o_ic_rdata,
    output logic                               o_ic_rlast,
    output logic                               o_ic_rvalid,
    input  logic                               i_ic_rready,
    // data cache
    input  logic [cache_mem_pkg::ADDR_W-1:0]   i_dc_araddr,
    input  logic [cache_mem_pkg::LEN_W-1:0]    i_dc_arlen,
    input  logic                               i_dc_arvalid,
    output logic                               o_dc_arready,
    output logic [cache_mem_pkg::DATA_W-1:0]   o_dc_rdata,
    output logic                               o_dc_rlast,
    output logic                               o_dc_rvalid,
    input  logic                               i_dc_rready,
    input  logic [cache_mem_pkg::ADDR_W-1:0]   i_dc_awaddr,
    input  logic [cache_mem_pkg::LEN_W-1:0]    i_dc_awlen,
    input  logic                               i_dc_awvalid,
    output logic                               o_dc_awready,
    input  logic [cache_mem_pkg::DATA_W-1:0]   i_dc_wdata,
    input  logic [cache_mem_pkg::DATA_W/8-1:0] i_dc_wstrb,
    input  logic                               i_dc_wlast,
    input  logic                               i_dc_wvalid,
    output logic                               o_dc_wready,
    output logic                               o_dc_bvalid,
    input  logic                               i_dc_bready
);

    import cache_mem_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    // shared read bus
    logic [ADDR_W-1:0]   bus_araddr;
    logic [LEN_W-1:0]    bus_arlen;
    req_id_t             bus_arid;
    logic                bus_arvalid;
    logic                bus_arready;
    logic [DATA_W-1:0]   bus_rdata;
    req_id_t             bus_rid;
    logic                bus_rlast;
    logic                bus_rvalid;
    logic                bus_rready;

    // ram ports
    logic [AW-1:0]       mem_raddr;
    logic [DATA_W-1:0]   mem_rdata;
    logic                mem_we;
    logic [AW-1:0]       mem_waddr;
    logic [DATA_W-1:0]   mem_wdata;
    logic [DATA_W/8-1:0] mem_wstrb;

    req_arbiter u_arbiter (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_ic_araddr   (i_ic_araddr),
        .i_ic_arlen    (i_ic_arlen),
        .i_ic_arvalid  (i_ic_arvalid),
        .i_dc_araddr   (i_dc_araddr),
        .i_dc_arlen    (i_dc_arlen),
        .i_dc_arvalid  (i_dc_arvalid),
        .i_bus_arready (bus_arready),
        .o_ic_arready  (o_ic_arready),
        .o_dc_arready  (o_dc_arready),
        .o_bus_araddr  (bus_araddr),
        .o_bus_arlen   (bus_arlen),
        .o_bus_arid    (bus_arid),
        .o_bus_arvalid (bus_arvalid)
    );

    resp_router u_router (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_bus_rdata  (bus_rdata),
        .i_bus_rid    (bus_rid),
        .i_bus_rlast  (bus_rlast),
        .i_bus_rvalid (bus_rvalid),
        .i_ic_rready  (i_ic_rready),
        .i_dc_rready  (i_dc_rready),
        .o_bus_rready (bus_rready),
        .o_ic_rdata   (o_ic_rdata),
        .o_ic_rlast   (o_ic_rlast),
        .o_ic_rvalid  (o_ic_rvalid),
        .o_dc_rdata   (o_dc_rdata),
        .o_dc_rlast   (o_dc_rlast),
        .o_dc_rvalid  (o_dc_rvalid)
    );

    axi_read_engine #(
        .MEM_WORDS (MEM_WORDS)
    ) u_read_engine (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_araddr    (bus_araddr),
        .i_arlen     (bus_arlen),
        .i_arid      (bus_arid),
        .i_arvalid   (bus_arvalid),
        .i_rready    (bus_rready),
        .i_mem_rdata (mem_rdata),
        .o_arready   (bus_arready),
        .o_rdata     (bus_rdata),
        .o_rid       (bus_rid),
        .o_rlast     (bus_rlast),
        .o_rvalid    (bus_rvalid),
        .o_mem_raddr (mem_raddr)
    );

    // single writer, so the data cache drives the engine directly
    axi_write_engine #(
        .MEM_WORDS (MEM_WORDS)
    ) u_write_engine (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_awaddr    (i_dc_awaddr),
        .i_awlen     (i_dc_awlen),
        .i_awvalid   (i_dc_awvalid),
        .i_wdata     (i_dc_wdata),
        .i_wstrb     (i_dc_wstrb),
        .i_wlast     (i_dc_wlast),
        .i_wvalid    (i_dc_wvalid),
        .i_bready    (i_dc_bready),
        .o_awready   (o_dc_awready),
        .o_wready    (o_dc_wready),
        .o_bvalid    (o_dc_bvalid),
        .o_mem_we    (mem_we),
        .o_mem_waddr (mem_waddr),
        .o_mem_wdata (mem_wdata),
        .o_mem_wstrb (mem_wstrb)
    );

    mem_array #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk     (clk),
        .i_raddr (mem_raddr),
        .i_we    (mem_we),
        .i_waddr (mem_waddr),
        .i_wdata (mem_wdata),
        .i_wstrb (mem_wstrb),
        .o_rdata (mem_rdata)
    );

endmodule

/* tb/tb_cache_mem.sv */
`timescale 1ns/100ps

module tb_cache_mem;

    import cache_mem_pkg::*;

    localparam int MEM_WORDS  = 256;
    localparam int WAIT_LIMIT = 2000;

    logic                clk = 1'b0;
    logic                i_rst_n;
    logic [ADDR_W-1:0]   i_ic_araddr;
    logic [LEN_W-1:0]    i_ic_arlen;
    logic                i_ic_arvalid;
    logic                o_ic_arready;
    logic [DATA_W-1:0]   o_ic_rdata;
    logic                o_ic_rlast;
    logic                o_ic_rvalid;
    logic                i_ic_rready = 1'b1;
    logic [ADDR_W-1:0]   i_dc_araddr;
    logic [LEN_W-1:0]    i_dc_arlen;
    logic                i_dc_arvalid;
    logic                o_dc_arready;
    logic [DATA_W-1:0]   o_dc_rdata;
    logic                o_dc_rlast;
    logic                o_dc_rvalid;
    logic                i_dc_rready = 1'b1;
    logic [ADDR_W-1:0]   i_dc_awaddr;
    logic [LEN_W-1:0]    i_dc_awlen;
    logic                i_dc_awvalid;
    logic                o_dc_awready;
    logic [DATA_W-1:0]   i_dc_wdata;
    logic [DATA_W/8-1:0] i_dc_wstrb;
    logic                i_dc_wlast;
    logic                i_dc_wvalid;
    logic                o_dc_wready;
    logic                o_dc_bvalid;
    logic                i_dc_bready;

    // reference memory and expected beats, {last, data}
    logic [DATA_W-1:0]   shadow [MEM_WORDS];
    logic [DATA_W:0]     ic_exp [$];
    logic [DATA_W:0]     dc_exp [$];
    int                  seed = 88;
    int                  errors = 0;
    int                  beats_seen = 0;
    int                  bresp_count = 0;
    int                  cycle = 0;
    int                  ic_ar_cycle;
    int                  dc_ar_cycle;
    int                  wr_ptr;
    logic                bp_on = 1'b0;
    logic [31:0]         rnd;

    cache_mem_top #(
        .MEM_WORDS (MEM_WORDS)
    ) uut (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_ic_araddr  (i_ic_araddr),
        .i_ic_arlen   (i_ic_arlen),
        .i_ic_arvalid (i_ic_arvalid),
        .o_ic_arready (o_ic_arready),
        .o_ic_rdata   (o_ic_rdata),
        .o_ic_rlast   (o_ic_rlast),
        .o_ic_rvalid  (o_ic_rvalid),
        .i_ic_rready  (i_ic_rready),
        .i_dc_araddr  (i_dc_araddr),
        .i_dc_arlen   (i_dc_arlen),
        .i_dc_arvalid (i_dc_arvalid),
        .o_dc_arready (o_dc_arready),
        .o_dc_rdata   (o_dc_rdata),
        .o_dc_rlast   (o_dc_rlast),
        .o_dc_rvalid  (o_dc_rvalid),
        .i_dc_rready  (i_dc_rready),
        .i_dc_awaddr  (i_dc_awaddr),
        .i_dc_awlen   (i_dc_awlen),
        .i_dc_awvalid (i_dc_awvalid),
        .o_dc_awready (o_dc_awready),
        .i_dc_wdata   (i_dc_wdata),
        .i_dc_wstrb   (i_dc_wstrb),
        .i_dc_wlast   (i_dc_wlast),
        .i_dc_wvalid  (i_dc_wvalid),
        .o_dc_wready  (o_dc_wready),
        .o_dc_bvalid  (o_dc_bvalid),
        .i_dc_bready  (i_dc_bready)
    );

    always #50 clk = ~clk;

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("beats=%0d errors=%0d timeouts=1", beats_seen, errors);
        $display("TEST FAILED");
        $finish;
    endtask

    // expected beats of one burst, taken from the shadow at the address transfer
    task automatic queue_burst(input bit is_inst, input logic [ADDR_W-1:0] addr,
                               input logic [LEN_W-1:0] len);
        int              base;
        logic [DATA_W:0] beat;
        base = int'((addr >> 2) % MEM_WORDS);
        for (int k = 0; k <= int'(len); k++) begin
            beat = {k == int'(len), shadow[(base + k) % MEM_WORDS]};
            if (is_inst) begin
                ic_exp.push_back(beat);
            end else begin
                dc_exp.push_back(beat);
            end
        end
    endtask

    task automatic check_beat(input bit is_inst, input logic [DATA_W-1:0] data,
                              input logic last);
        logic [DATA_W:0] exp;
        string           port;
        bit              pending;
        port    = is_inst ? "o_ic" : "o_dc";
        pending = is_inst ? (ic_exp.size() != 0) : (dc_exp.size() != 0);
        assert (pending) else begin
            $display("Unexpected read beat on %s port at %0t", port, $time);
            errors++;
        end
        if (pending) begin
            if (is_inst) begin
                exp = ic_exp.pop_front();
            end else begin
                exp = dc_exp.pop_front();
            end
            beats_seen++;
            assert (data == exp[DATA_W-1:0]) else begin
                $display("Mismatch at %0t: %s_rdata expected %h got %h",
                         $time, port, exp[DATA_W-1:0], data);
                errors++;
            end
            assert (last == exp[DATA_W]) else begin
                $display("Mismatch at %0t: %s_rlast expected %b got %b",
                         $time, port, exp[DATA_W], last);
                errors++;
            end
        end
    endtask

    // handshakes sampled at the edge
    always @(posedge clk) begin
        cycle++;
        if (i_rst_n) begin
            if (i_ic_arvalid && o_ic_arready) begin
                queue_burst(1'b1, i_ic_araddr, i_ic_arlen);
                ic_ar_cycle = cycle;
            end
            if (i_dc_arvalid && o_dc_arready) begin
                queue_burst(1'b0, i_dc_araddr, i_dc_arlen);
                dc_ar_cycle = cycle;
            end
            if (i_dc_awvalid && o_dc_awready) begin
                wr_ptr = int'((i_dc_awaddr >> 2) % MEM_WORDS);
            end
            if (i_dc_wvalid && o_dc_wready) begin
                for (int b = 0; b < DATA_W / 8; b++) begin
                    if (i_dc_wstrb[b]) begin
                        shadow[wr_ptr][b*8 +: 8] = i_dc_wdata[b*8 +: 8];
                    end
                end
                wr_ptr = (wr_ptr + 1) % MEM_WORDS;
            end
            if (o_dc_bvalid && i_dc_bready) begin
                bresp_count++;
            end
            if (o_ic_rvalid && i_ic_rready) begin
                check_beat(1'b1, o_ic_rdata, o_ic_rlast);
            end
            if (o_dc_rvalid && i_dc_rready) begin
                check_beat(1'b0, o_dc_rdata, o_dc_rlast);
            end
        end
    end

    // a stalled beat must hold
    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_ic_rvalid && !i_ic_rready |=> o_ic_rvalid && $stable(o_ic_rdata) && $stable(o_ic_rlast))
    else begin
        $display("Instruction-cache beat changed or vanished while stalled at %0t", $time);
        errors++;
    end

    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_dc_rvalid && !i_dc_rready |=> o_dc_rvalid && $stable(o_dc_rdata) && $stable(o_dc_rlast))
    else begin
        $display("Data-cache beat changed or vanished while stalled at %0t", $time);
        errors++;
    end

    always @(posedge clk) begin
        if (bp_on) begin
            rnd = $random(seed);
            i_ic_rready <= rnd[0];
            i_dc_rready <= rnd[3];
        end else begin
            i_ic_rready <= 1'b1;
            i_dc_rready <= 1'b1;
        end
    end

    task automatic issue_read(input bit is_inst, input logic [ADDR_W-1:0] addr, input int beats);
        int n;
        @(posedge clk);
        if (is_inst) begin
            i_ic_araddr  <= addr;
            i_ic_arlen   <= LEN_W'(beats - 1);
            i_ic_arvalid <= 1'b1;
        end else begin
            i_dc_araddr  <= addr;
            i_dc_arlen   <= LEN_W'(beats - 1);
            i_dc_arvalid <= 1'b1;
        end
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge clk);
            if (is_inst ? o_ic_arready : o_dc_arready) begin
                break;
            end
        end
        if (n == WAIT_LIMIT) begin
            stop_on_timeout("read address was never accepted");
        end
        if (is_inst) begin
            i_ic_arvalid <= 1'b0;
        end else begin
            i_dc_arvalid <= 1'b0;
        end
    endtask

    task automatic write_burst(input logic [ADDR_W-1:0] addr, input int beats);
        int n;
        @(posedge clk);
        i_dc_awaddr  <= addr;
        i_dc_awlen   <= LEN_W'(beats - 1);
        i_dc_awvalid <= 1'b1;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge clk);
            if (o_dc_awready) begin
                break;
            end
        end
        if (n == WAIT_LIMIT) begin
            stop_on_timeout("write address was never accepted");
        end
        i_dc_awvalid <= 1'b0;
        for (int k = 0; k < beats; k++) begin
            i_dc_wdata  <= $random(seed);
            // partial lanes, full word on the last beat
            i_dc_wstrb  <= (k == beats - 1) ? 4'hF : 4'b0011 << k;
            i_dc_wlast  <= (k == beats - 1);
            i_dc_wvalid <= 1'b1;
            for (n = 0; n < WAIT_LIMIT; n++) begin
                @(posedge clk);
                if (o_dc_wready) begin
                    break;
                end
            end
            if (n == WAIT_LIMIT) begin
                stop_on_timeout("write beat was never accepted");
            end
        end
        i_dc_wvalid <= 1'b0;
        i_dc_wlast  <= 1'b0;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge clk);
            if (o_dc_bvalid) begin
                break;
            end
        end
        if (n == WAIT_LIMIT) begin
            stop_on_timeout("write response never arrived");
        end
    endtask

    task automatic wait_reads_done();
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge clk);
            if (ic_exp.size() == 0 && dc_exp.size() == 0) begin
                break;
            end
        end
        if (n == WAIT_LIMIT) begin
            stop_on_timeout("read beats still missing");
        end
    endtask

    initial begin
        logic [ADDR_W-1:0] addr_i [6];
        logic [ADDR_W-1:0] addr_d [6];
        int                beats_i [6];
        int                beats_d [6];
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = DATA_W'(i * 4) + MEM_INIT_BASE;
        end
        i_rst_n      <= 1'b0;
        i_ic_araddr  <= '0;
        i_ic_arlen   <= '0;
        i_ic_arvalid <= 1'b0;
        i_dc_araddr  <= '0;
        i_dc_arlen   <= '0;
        i_dc_arvalid <= 1'b0;
        i_dc_awaddr  <= '0;
        i_dc_awlen   <= '0;
        i_dc_awvalid <= 1'b0;
        i_dc_wdata   <= '0;
        i_dc_wstrb   <= '0;
        i_dc_wlast   <= 1'b0;
        i_dc_wvalid  <= 1'b0;
        i_dc_bready  <= 1'b1;
        repeat (5) @(posedge clk);
        i_rst_n <= 1'b1;
        // quiet bus until the first request
        repeat (4) begin
            @(posedge clk);
            assert ({o_ic_rvalid, o_dc_rvalid, o_dc_bvalid, o_ic_arready, o_dc_arready,
                     o_dc_awready, o_dc_wready, uut.bus_arvalid, uut.bus_rvalid} == '0)
            else begin
                $display("Mismatch at %0t: idle controls expected 0 got %b", $time,
                         {o_ic_rvalid, o_dc_rvalid, o_dc_bvalid, o_ic_arready, o_dc_arready,
                          o_dc_awready, o_dc_wready, uut.bus_arvalid, uut.bus_rvalid});
                errors++;
            end
        end
        issue_read(1'b1, 32'h0000_0040, 4);
        wait_reads_done();
        issue_read(1'b0, 32'h0000_0100, 6);
        wait_reads_done();
        // partial writes across the top of memory, then read back
        bresp_count = 0;
        write_burst(32'h0000_03F8, 4);
        issue_read(1'b0, 32'h0000_03F8, 4);
        wait_reads_done();
        assert (bresp_count == 1) else begin
            $display("Mismatch at %0t: o_dc_bvalid count expected 1 got %0d",
                     $time, bresp_count);
            errors++;
        end
        fork
            issue_read(1'b0, 32'h0000_0080, 3);
            issue_read(1'b1, 32'h0000_0300, 5);
        join
        wait_reads_done();
        assert (dc_ar_cycle <= ic_ar_cycle) else begin
            $display("Data-cache address transfer came after the instruction cache's");
            errors++;
        end
        // random burst pairs for the back-pressure phase
        for (int r = 0; r < 6; r++) begin
            addr_i[r]  = $random(seed) & 32'h0000_03FC;
            addr_d[r]  = $random(seed) & 32'h0000_03FC;
            beats_i[r] = 1 + ($random(seed) & 7);
            beats_d[r] = 1 + ($random(seed) & 7);
        end
        bp_on <= 1'b1;
        for (int r = 0; r < 6; r++) begin
            fork
                issue_read(1'b1, addr_i[r], beats_i[r]);
                issue_read(1'b0, addr_d[r], beats_d[r]);
            join
        end
        wait_reads_done();
        bp_on <= 1'b0;
        repeat (2) @(posedge clk);
        $display("beats=%0d errors=%0d timeouts=0", beats_seen, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* cache_mem_top.f */
logic/cache_mem_pkg.sv
logic/req_arbiter.sv
logic/resp_router.sv
logic/axi_read_engine.sv
logic/axi_write_engine.sv
logic/mem_array.sv
logic/cache_mem_top.sv
tb/tb_cache_mem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_cache_mem
FILELIST  := cache_mem_top.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
